/* vlog.f */
+incdir+verilog
verilog/dcache_addr_pkg.sv
verilog/dcache_bus_pkg.sv
verilog/dcache_ifs.sv
verilog/dcache_ctrl.sv
verilog/line_store.sv
verilog/burst_engine.sv
verilog/dcache_top.sv
bench/mem_responder.sv
bench/dcache_tb.sv

/* bench/dcache_tb.sv */
/*
 * Data cache testbench
 * Random reads, byte-masked writes and flushes over four line tags,
 * checked against a model line and a model memory. The burst memory
 * reports each write-back and refill burst it serves.
 */

`timescale 1ns/1ps
`default_nettype none

module dcache_tb import dcache_addr_pkg::*, dcache_bus_pkg::*;;

    localparam int        SEED        = 10325;
    localparam int        N_REQ       = 400;
    localparam int        STALL_LIMIT = 4000;
    // Four tags from here up, low two tag bits select the memory line
    localparam line_tag_t TAG_BASE    = 23'h0248C0;

    logic      clk;
    logic      rst_n;
    addr_t     address;
    word_t     write_data;
    logic      read_enable;
    logic      write_enable;
    byte_en_t  byte_enable;
    logic      flush_order;
    word_t     read_data;
    logic      cache_stall;

    logic      awvalid, awready, wvalid, wready, wlast, bvalid, bready;
    logic      arvalid, arready, rvalid, rready, rlast;
    addr_t     awaddr, araddr, wb_addr_seen, rd_addr_seen;
    word_t     wdata, rdata;
    bus_resp_t bresp;
    int        wb_bursts, rd_bursts;
    logic      form_err;

    // Reference model
    word_t     model_mem [512];
    word_t     model_line [128];
    logic      m_valid;
    logic      m_dirty;
    int        m_slot;
    int        seed_init;

    dcache_top i_dcache_top (
        .clk (clk), .rst_n (rst_n), .address (address), .write_data (write_data),
        .read_enable (read_enable), .write_enable (write_enable),
        .byte_enable (byte_enable), .flush_order (flush_order),
        .read_data (read_data), .cache_stall (cache_stall),
        .awvalid (awvalid), .awready (awready), .awaddr (awaddr),
        .wvalid (wvalid), .wready (wready), .wdata (wdata), .wlast (wlast),
        .bvalid (bvalid), .bready (bready), .bresp (bresp),
        .arvalid (arvalid), .arready (arready), .araddr (araddr),
        .rvalid (rvalid), .rready (rready), .rdata (rdata), .rlast (rlast)
    );

    mem_responder i_mem_responder (
        .clk (clk), .rst_n (rst_n),
        .awvalid (awvalid), .awready (awready), .awaddr (awaddr),
        .wvalid (wvalid), .wready (wready), .wdata (wdata), .wlast (wlast),
        .bvalid (bvalid), .bready (bready), .bresp (bresp),
        .arvalid (arvalid), .arready (arready), .araddr (araddr),
        .rvalid (rvalid), .rready (rready), .rdata (rdata), .rlast (rlast),
        .wb_bursts (wb_bursts), .rd_bursts (rd_bursts),
        .wb_addr_seen (wb_addr_seen), .rd_addr_seen (rd_addr_seen),
        .form_err (form_err)
    );

    // 8 ns clock
    initial clk = 1'b0;
    always #4 clk = ~clk;

    // ----------------------------------------
    // Helpers
    // ----------------------------------------

    task automatic stop_run();
        $display("tests failed");
        $fatal(1, "Simulation stopped at the first error");
    endtask

    task automatic check_value(input string test_name, input logic [31:0] expected,
                               input logic [31:0] actual);
        assert (actual === expected) else begin
            $display("Mismatch %s: expected %h, actual %h", test_name, expected, actual);
            stop_run();
        end
    endtask

    function automatic addr_t line_addr(input int slot, input int idx);
        line_tag_t   t;
        word_index_t w;
        t = TAG_BASE + line_tag_t'(slot);
        w = word_index_t'(idx);
        return {t, w, 2'b00};
    endfunction

    // Initial memory contents, spread over the whole address
    function automatic word_t fill_pattern(input addr_t a);
        return (a * 32'h9E3779B1) ^ {a[15:0], a[31:16]};
    endfunction

    // First look tells a hit from a miss, then wait for the stall to end
    task automatic wait_stall_low(input string test_name, input logic exp_stall);
        int cycles;
        cycles = 0;
        @(negedge clk);
        check_value(test_name, exp_stall, cache_stall);
        while (cache_stall) begin
            cycles++;
            assert (cycles < STALL_LIMIT) else begin
                $display("Timeout in %s: cache_stall stayed high for %0d cycles",
                         test_name, cycles);
                stop_run();
            end
            @(negedge clk);
        end
    endtask

    // Whole line in the burst memory against the model
    task automatic check_line_in_memory(input int slot);
        for (int i = 0; i < 128; i++) begin
            check_value("write_back_data", model_mem[slot*128 + i],
                        i_mem_responder.mem[slot*128 + i]);
        end
    endtask

    // Burst form errors seen by the memory
    always @(posedge clk) begin
        assert (!(rst_n && form_err)) else begin
            $display("Burst memory saw a malformed burst");
            stop_run();
        end
    end

    // ----------------------------------------
    // Requests
    // ----------------------------------------

    task automatic do_access(input int slot, input int idx, input logic wr,
                             input word_t wd, input byte_en_t be);
        logic  acc;
        logic  miss;
        logic  exp_wb;
        int    old_slot;
        int    wb_before;
        int    rd_before;
        word_t mask;
        acc       = !wr || (be != 4'b0000);
        miss      = acc && !(m_valid && m_slot == slot);
        exp_wb    = miss && m_valid && m_dirty;
        old_slot  = m_slot;
        wb_before = wb_bursts;
        rd_before = rd_bursts;
        @(posedge clk);
        address      <= line_addr(slot, idx);
        write_data   <= wd;
        byte_enable  <= be;
        read_enable  <= !wr;
        write_enable <= wr;
        flush_order  <= 1'b0;
        wait_stall_low(wr ? "write_stall" : "read_stall", miss);
        // Dirty victim lands in memory before the refill
        if (exp_wb) begin
            for (int i = 0; i < 128; i++) begin
                model_mem[old_slot*128 + i] = model_line[i];
            end
        end
        check_value("write_back_count", wb_before + (exp_wb ? 1 : 0), wb_bursts);
        if (exp_wb) begin
            check_value("write_back_addr", line_addr(old_slot, 0), wb_addr_seen);
            check_line_in_memory(old_slot);
        end
        if (miss) begin
            for (int i = 0; i < 128; i++) begin
                model_line[i] = model_mem[slot*128 + i];
            end
            m_valid = 1'b1;
            m_dirty = 1'b0;
            m_slot  = slot;
            check_value("refill_addr", line_addr(slot, 0), rd_addr_seen);
        end
        check_value("refill_count", rd_before + (miss ? 1 : 0), rd_bursts);
        if (!wr) begin
            check_value("read", model_line[idx], read_data);
        end else if (be != 4'b0000) begin
            // Only enabled bytes change, committed at the next edge
            for (int b = 0; b < 4; b++) begin
                mask[8*b +: 8] = be[b] ? 8'hFF : 8'h00;
            end
            model_line[idx] = (model_line[idx] & ~mask) | (wd & mask);
            m_dirty = 1'b1;
        end
    endtask

    task automatic do_flush();
        logic exp_wb;
        int   wb_before;
        exp_wb    = m_valid;
        wb_before = wb_bursts;
        @(posedge clk);
        read_enable  <= 1'b0;
        write_enable <= 1'b0;
        flush_order  <= 1'b1;
        @(posedge clk);
        flush_order  <= 1'b0;
        wait_stall_low("flush_stall", exp_wb);
        // Valid line goes back whole and stays clean
        if (exp_wb) begin
            for (int i = 0; i < 128; i++) begin
                model_mem[m_slot*128 + i] = model_line[i];
            end
            m_dirty = 1'b0;
        end
        check_value("flush_count", wb_before + (exp_wb ? 1 : 0), wb_bursts);
        if (exp_wb) begin
            check_value("flush_addr", line_addr(m_slot, 0), wb_addr_seen);
            check_line_in_memory(m_slot);
        end
    endtask

    task automatic run_random_request();
        int op;
        int slot;
        int idx;
        op   = $urandom % 16;
        // Mostly stay on the cached line to get hits
        slot = ($urandom % 4 == 0) ? ($urandom % 4) : m_slot;
        idx  = $urandom % 128;
        if (op == 0) begin
            do_flush();
        end else if (op < 8) begin
            do_access(slot, idx, 1'b0, '0, 4'b0000);
        end else begin
            do_access(slot, idx, 1'b1, $urandom, byte_en_t'($urandom % 16));
        end
    endtask

    // ----------------------------------------
    // Main sequence
    // ----------------------------------------

    initial begin
        seed_init    = $urandom(SEED);
        rst_n        = 1'b0;
        address      = '0;
        write_data   = '0;
        read_enable  = 1'b0;
        write_enable = 1'b0;
        byte_enable  = '0;
        flush_order  = 1'b0;
        m_valid      = 1'b0;
        m_dirty      = 1'b0;
        m_slot       = 0;
        for (int i = 0; i < 512; i++) begin
            model_mem[i]              = fill_pattern(line_addr(i / 128, i % 128));
            i_mem_responder.mem[i]    = model_mem[i];
        end
        repeat (10) @(posedge clk);
        rst_n <= 1'b1;
        @(negedge clk);
        check_value("reset_cache_stall", 0, cache_stall);
        check_value("reset_awvalid", 0, awvalid);
        check_value("reset_wvalid", 0, wvalid);
        check_value("reset_arvalid", 0, arvalid);
        check_value("reset_bready", 0, bready);
        check_value("reset_rready", 0, rready);
        for (int n = 0; n < N_REQ; n++) begin
            run_random_request();
        end
        @(posedge clk);
        read_enable  <= 1'b0;
        write_enable <= 1'b0;
        @(posedge clk);
        $display("all tests passed");
        $finish;
    end

endmodule

`default_nettype wire

/* bench/mem_responder.sv */
/*
 * Behavioural burst memory
 * Backing store for the data cache testbench. Serves full-line write-back
 * and refill bursts with random ready and valid gaps, checks the burst
 * form and counts the bursts it has served.
 */

`timescale 1ns/1ps
`default_nettype none

module mem_responder import dcache_addr_pkg::*, dcache_bus_pkg::*; (
    input  logic      clk,
    input  logic      rst_n,
    input  logic      awvalid,
    output logic      awready,
    input  addr_t     awaddr,
    input  logic      wvalid,
    output logic      wready,
    input  word_t     wdata,
    input  logic      wlast,
    output logic      bvalid,
    input  logic      bready,
    output bus_resp_t bresp,
    input  logic      arvalid,
    output logic      arready,
    input  addr_t     araddr,
    output logic      rvalid,
    input  logic      rready,
    output word_t     rdata,
    output logic      rlast,
    output int        wb_bursts,
    output int        rd_bursts,
    output addr_t     wb_addr_seen,
    output addr_t     rd_addr_seen,
    output logic      form_err
);

    // Four lines of 128 words, indexed by tag[1:0] and word index
    word_t mem [512];

    addr_t w_base;
    addr_t r_base;
    logic  w_active;
    logic  r_active;
    int    w_cnt;
    int    r_cnt;
    int    r_next;
    logic  w_err;
    logic  r_err;

    assign form_err = w_err | r_err;

    function automatic int mem_idx(input addr_t base, input int cnt);
        return base[10:9] * 128 + cnt;
    endfunction

    // Bus outputs quiet from time zero
    initial begin
        awready   = 1'b0;
        wready    = 1'b0;
        bvalid    = 1'b0;
        bresp     = RESP_OKAY;
        arready   = 1'b0;
        rvalid    = 1'b0;
        rdata     = '0;
        rlast     = 1'b0;
        w_err     = 1'b0;
        r_err     = 1'b0;
        wb_bursts = 0;
        rd_bursts = 0;
    end

    // ----------------------------------------
    // Write-back side
    // ----------------------------------------

    always @(posedge clk) begin
        if (!rst_n) begin
            awready   <= 1'b0;
            wready    <= 1'b0;
            bvalid    <= 1'b0;
            bresp     <= RESP_OKAY;
            w_active  <= 1'b0;
            w_cnt     <= 0;
            w_err     <= 1'b0;
            wb_bursts <= 0;
        end else begin
            // Random gaps on both ready lines
            awready <= !w_active && !bvalid && ($urandom % 3 != 0);
            wready  <= w_active && ($urandom % 4 != 0);
            if (awvalid && awready) begin
                assert (awaddr[8:0] == 9'd0) else begin
                    $display("Write burst address %h is not line aligned", awaddr);
                    w_err <= 1'b1;
                end
                w_base   <= awaddr;
                w_cnt    <= 0;
                w_active <= 1'b1;
                awready  <= 1'b0;
            end
            if (wvalid && wready) begin
                assert (w_active) else begin
                    $display("Write beat arrived outside a burst");
                    w_err <= 1'b1;
                end
                // wlast only on beat 128
                assert (wlast == (w_cnt == 127)) else begin
                    $display("Mismatch write_burst wlast at beat %0d: expected %0b, actual %0b",
                             w_cnt, (w_cnt == 127), wlast);
                    w_err <= 1'b1;
                end
                mem[mem_idx(w_base, w_cnt)] <= wdata;
                w_cnt <= w_cnt + 1;
                if (w_cnt == 127) begin
                    w_active <= 1'b0;
                    wready   <= 1'b0;
                    bvalid   <= 1'b1;
                end
            end
            if (bvalid && bready) begin
                bvalid       <= 1'b0;
                wb_bursts    <= wb_bursts + 1;
                wb_addr_seen <= w_base;
            end
        end
    end

    // ----------------------------------------
    // Refill side
    // ----------------------------------------

    always @(posedge clk) begin
        if (!rst_n) begin
            arready   <= 1'b0;
            rvalid    <= 1'b0;
            rlast     <= 1'b0;
            r_active  <= 1'b0;
            r_cnt     <= 0;
            r_err     <= 1'b0;
            rd_bursts <= 0;
        end else begin
            arready <= !r_active && ($urandom % 3 != 0);
            if (arvalid && arready) begin
                assert (araddr[8:0] == 9'd0) else begin
                    $display("Read burst address %h is not line aligned", araddr);
                    r_err <= 1'b1;
                end
                r_base       <= araddr;
                rd_addr_seen <= araddr;
                rd_bursts    <= rd_bursts + 1;
                r_cnt        <= 0;
                r_active     <= 1'b1;
                arready      <= 1'b0;
            end
            if (r_active) begin
                r_next = r_cnt + ((rvalid && rready) ? 1 : 0);
                r_cnt <= r_next;
                if (r_next == 128) begin
                    r_active <= 1'b0;
                    rvalid   <= 1'b0;
                    rlast    <= 1'b0;
                end else if (!rvalid || rready) begin
                    // Valid beat held until taken, new beat may pause
                    rvalid <= ($urandom % 4 != 0);
                    rdata  <= mem[mem_idx(r_base, r_next)];
                    rlast  <= (r_next == 127);
                end
            end
        end
    end

endmodule

`default_nettype wire

/* verilog/dcache_top.sv */
/*
 * Direct-mapped data cache, top level
 * One 512-byte line, CPU word port with byte enables and stall,
 * full-line valid/ready bursts for write-back and refill.
 */

`timescale 1ns/1ps
`default_nettype none

module dcache_top
    import dcache_addr_pkg::*;
    import dcache_bus_pkg::*;
(
    input  logic      clk,
    input  logic      rst_n,

    // CPU side
    input  addr_t     address,
    input  word_t     write_data,
    input  logic      read_enable,
    input  logic      write_enable,
    input  byte_en_t  byte_enable,
    input  logic      flush_order,
    output word_t     read_data,
    output logic      cache_stall,

    // Memory bus
    output logic      awvalid,
    input  logic      awready,
    output addr_t     awaddr,
    output logic      wvalid,
    input  logic      wready,
    output word_t     wdata,
    output logic      wlast,
    input  logic      bvalid,
    output logic      bready,
    input  bus_resp_t bresp,
    output logic      arvalid,
    input  logic      arready,
    output addr_t     araddr,
    input  logic      rvalid,
    output logic      rready,
    input  word_t     rdata,
    input  logic      rlast
);

    // Write hit commit from controller to store
    logic cpu_we;

    line_job_if  job_if ();
    line_port_if port_if ();

    // Hit detection, line state, job sequencing
    dcache_ctrl i_ctrl (
        .clk          (clk),
        .rst_n        (rst_n),
        .address      (address),
        .read_enable  (read_enable),
        .write_enable (write_enable),
        .byte_enable  (byte_enable),
        .flush_order  (flush_order),
        .cache_stall  (cache_stall),
        .cpu_we       (cpu_we),
        .job          (job_if.ctrl)
    );

    line_store i_store (
        .clk          (clk),
        .address      (address),
        .write_data   (write_data),
        .byte_enable  (byte_enable),
        .cpu_we       (cpu_we),
        .read_data    (read_data),
        .port         (port_if.store)
    );

    // Bursts on the memory bus
    burst_engine i_engine (
        .clk     (clk),
        .rst_n   (rst_n),
        .job     (job_if.engine),
        .port    (port_if.engine),
        .awvalid (awvalid),
        .awready (awready),
        .awaddr  (awaddr),
        .wvalid  (wvalid),
        .wready  (wready),
        .wdata   (wdata),
        .wlast   (wlast),
        .bvalid  (bvalid),
        .bready  (bready),
        .bresp   (bresp),
        .arvalid (arvalid),
        .arready (arready),
        .araddr  (araddr),
        .rvalid  (rvalid),
        .rready  (rready),
        .rdata   (rdata),
        .rlast   (rlast)
    );

endmodule

`default_nettype wire

/* verilog/burst_engine.sv */
/*
 * Line burst engine
 * Carries out controller jobs on the valid/ready memory bus.
 * Write-back sends the whole line in one incrementing burst and waits for
 * the response, refill reads the whole line into the line store.
 * job_done pulses when the last requested phase ends.
 */

`timescale 1ns/1ps
`default_nettype none

module burst_engine
    import dcache_addr_pkg::*;
    import dcache_bus_pkg::*;
(
    input  logic         clk,
    input  logic         rst_n,

    line_job_if.engine   job,
    line_port_if.engine  port,

    // Write address
    output logic         awvalid,
    input  logic         awready,
    output addr_t        awaddr,
    // Write data
    output logic         wvalid,
    input  logic         wready,
    output word_t        wdata,
    output logic         wlast,
    // Write response
    input  logic         bvalid,
    output logic         bready,
    input  bus_resp_t    bresp,
    // Read address
    output logic         arvalid,
    input  logic         arready,
    output addr_t        araddr,
    // Read data
    input  logic         rvalid,
    output logic         rready,
    input  word_t        rdata,
    input  logic         rlast
);

    burst_state_t state;
    word_index_t  ptr;
    // Refill follows the current write-back
    logic         fill_pend;
    logic         last_beat;

    assign last_beat = (ptr == word_index_t'(BURST_BEATS - 1));

    // ----------------------------------------
    // Bus outputs
    // ----------------------------------------

    // Address channels, held until accepted
    assign awvalid = (state == WB_ADDR);
    assign awaddr  = tag_base(job.wb_tag);
    assign arvalid = (state == FILL_ADDR);
    assign araddr  = tag_base(job.fill_tag);

    // Write data straight from the store at ptr
    assign wvalid = (state == WB_DATA);
    assign wdata  = port.wb_word;
    assign wlast  = wvalid & last_beat;

    assign bready = (state == WB_RESP);
    assign rready = (state == FILL_DATA);

    // Store port
    assign port.ptr       = ptr;
    assign port.fill_we   = rready & rvalid;
    assign port.fill_word = rdata;

    // Write response ends a flush, last read beat ends a fill
    assign job.job_done = (bready & bvalid & ~fill_pend) | (port.fill_we & last_beat);

    // ----------------------------------------
    // Burst FSM
    // ----------------------------------------

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state     <= IDLE;
            ptr       <= '0;
            fill_pend <= 1'b0;
        end else begin
            case (state)
                IDLE: begin
                    ptr <= '0;
                    // Write-back always goes before the fill
                    if (job.job_wb) begin
                        state     <= WB_ADDR;
                        fill_pend <= job.job_fill;
                    end else if (job.job_fill) begin
                        state     <= FILL_ADDR;
                        fill_pend <= 1'b0;
                    end
                end
                WB_ADDR: begin
                    if (awready) begin
                        state <= WB_DATA;
                    end
                end
                WB_DATA: begin
                    // Low wready holds wdata and ptr
                    if (wready) begin
                        ptr <= ptr + 1'b1;
                        if (last_beat) begin
                            state <= WB_RESP;
                        end
                    end
                end
                WB_RESP: begin
                    // ptr wrapped to zero, ready for the refill
                    if (bvalid) begin
                        state <= fill_pend ? FILL_ADDR : IDLE;
                    end
                end
                FILL_ADDR: begin
                    if (arready) begin
                        state <= FILL_DATA;
                    end
                end
                FILL_DATA: begin
                    if (rvalid) begin
                        ptr <= ptr + 1'b1;
                        if (last_beat) begin
                            state <= IDLE;
                        end
                    end
                end
                default: begin
                    state <= IDLE;
                end
            endcase
        end
    end

    // ----------------------------------------
    // Checks
    // ----------------------------------------

    // No error path, memory must answer OKAY
    assert property (@(posedge clk) disable iff (!rst_n)
        bvalid |-> (bresp == RESP_OKAY));

    // Memory closes the read burst exactly on beat 128
    assert property (@(posedge clk) disable iff (!rst_n)
        (rvalid && rready) |-> (rlast == last_beat));

endmodule

`default_nettype wire

/* verilog/line_store.sv */
/*
 * Cache line data store
 * 128-word array of the single line. CPU port with byte-masked writes
 * and combinational reads, burst port for fill writes and write-back reads.
 */

`timescale 1ns/1ps
`default_nettype none

`include "dcache_cfg.svh"

module line_store import dcache_addr_pkg::*; (
    input  logic      clk,
    input  addr_t     address,
    input  word_t     write_data,
    input  byte_en_t  byte_enable,
    input  logic      cpu_we,
    output word_t     read_data,
    line_port_if.store port
);

    // Line data
    word_t       data_q [`DC_LINE_WORDS];

    word_index_t cpu_idx;
    word_t       be_mask;

    assign cpu_idx = addr_index(address);
    assign be_mask = byte_mask(byte_enable);

    // ----------------------------------------
    // Writes
    // ----------------------------------------

    always_ff @(posedge clk) begin
        if (cpu_we) begin
            // Keep bytes that are not enabled
            data_q[cpu_idx] <= (data_q[cpu_idx] & ~be_mask) | (write_data & be_mask);
        end else if (port.fill_we) begin
            // Refill beat overwrites the whole word
            data_q[port.ptr] <= port.fill_word;
        end
    end

    // ----------------------------------------
    // Reads
    // ----------------------------------------

    // CPU read, no stall on a hit
    assign read_data = data_q[cpu_idx];

    // Write-back stream follows the engine pointer
    assign port.wb_word = data_q[port.ptr];

    // CPU writes only while no job runs, so never during a refill
    assert property (@(posedge clk) cpu_we |-> !port.fill_we);

endmodule

`default_nettype wire

/* verilog/dcache_ctrl.sv */
/*
 * Cache request controller
 * Keeps tag, valid and dirty state of the line, detects hits, stalls the
 * CPU on a miss and hands write-back and fill jobs to the burst engine.
 * A flush order writes a valid line back and leaves it clean.
 */

`timescale 1ns/1ps
`default_nettype none

module dcache_ctrl import dcache_addr_pkg::*; (
    input  logic     clk,
    input  logic     rst_n,
    input  addr_t    address,
    input  logic     read_enable,
    input  logic     write_enable,
    input  byte_en_t byte_enable,
    input  logic     flush_order,
    output logic     cache_stall,
    output logic     cpu_we,
    line_job_if.ctrl job
);

    // Line state
    logic      line_valid;
    logic      line_dirty;
    line_tag_t line_tag;

    // Job in flight, cleared on job_done
    logic      busy;
    // Tag loaded into the line when the job ends
    line_tag_t pend_tag;

    line_tag_t req_tag;
    logic      wr_req;
    logic      access;
    logic      hit;
    logic      flush_take;
    logic      miss_take;

    // ----------------------------------------
    // Request decode
    // ----------------------------------------

    assign req_tag = addr_tag(address);
    // No byte enabled means no write at all
    assign wr_req  = write_enable & |byte_enable;
    assign access  = read_enable | wr_req;
    assign hit     = line_valid & (req_tag == line_tag);

    // Flush of an invalid line is dropped
    assign flush_take = ~busy & flush_order & line_valid;
    // Flush goes first, a pending miss is taken after it
    assign miss_take  = ~busy & access & ~hit & ~flush_take;

    // Stall at once on a miss, then for the whole job
    assign cache_stall = busy | (access & ~hit);

    // Write hit committed at the next edge
    assign cpu_we = ~busy & wr_req & hit;

    // ----------------------------------------
    // Job requests
    // ----------------------------------------

    // Dirty line goes back to memory before the refill
    assign job.job_wb   = flush_take | (miss_take & line_valid & line_dirty);
    assign job.job_fill = miss_take;
    assign job.wb_tag   = line_tag;
    // Engine reads fill_tag only after acceptance, pend_tag is loaded by then
    assign job.fill_tag = pend_tag;

    // ----------------------------------------
    // State update
    // ----------------------------------------

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            busy       <= 1'b0;
            line_valid <= 1'b0;
            line_dirty <= 1'b0;
        end else begin
            if (job.job_wb || job.job_fill) begin
                busy <= 1'b1;
            end else if (job.job_done) begin
                busy <= 1'b0;
            end

            // Fresh fill or finished write-back leaves a clean line
            if (job.job_done) begin
                line_valid <= 1'b1;
                line_dirty <= 1'b0;
            end else if (cpu_we) begin
                line_dirty <= 1'b1;
            end
        end
    end

    // Tag registers
    always_ff @(posedge clk) begin
        if (flush_take) begin
            // Flush keeps the same line
            pend_tag <= line_tag;
        end else if (miss_take) begin
            pend_tag <= req_tag;
        end

        if (job.job_done) begin
            line_tag <= pend_tag;
        end
    end

    // ----------------------------------------
    // Checks
    // ----------------------------------------

    // CPU never reads and writes in one cycle
    assert property (@(posedge clk) disable iff (!rst_n)
        !(read_enable && write_enable));

    // Engine reports done only for the job in flight
    assert property (@(posedge clk) disable iff (!rst_n)
        job.job_done |-> busy);

endmodule

`default_nettype wire

/* verilog/dcache_ifs.sv */
/*
 * Internal cache interfaces
 * line_job_if hands write-back and fill jobs from the controller to the
 * burst engine. line_port_if is the burst engine's port into the line store.
 */

`timescale 1ns/1ps
`default_nettype none

interface line_job_if import dcache_addr_pkg::*; ();

    // Job request bits, taken while the engine idles
    logic      job_wb;
    logic      job_fill;
    // Tag of the line in the cache, used for write-back
    line_tag_t wb_tag;
    // Tag of the line to fetch
    line_tag_t fill_tag;
    // One-cycle pulse at the end of the last phase
    logic      job_done;

    modport ctrl (
        output job_wb,
        output job_fill,
        output wb_tag,
        output fill_tag,
        input  job_done
    );

    modport engine (
        input  job_wb,
        input  job_fill,
        input  wb_tag,
        input  fill_tag,
        output job_done
    );

endinterface

interface line_port_if import dcache_addr_pkg::*; ();

    // Burst beat position in the line
    word_index_t ptr;
    logic        fill_we;
    word_t       fill_word;
    // Word at ptr, combinational
    word_t       wb_word;

    modport engine (
        output ptr,
        output fill_we,
        output fill_word,
        input  wb_word
    );

    modport store (
        input  ptr,
        input  fill_we,
        input  fill_word,
        output wb_word
    );

endinterface

`default_nettype wire

/* verilog/dcache_bus_pkg.sv */
/*
 * Memory burst bus types
 * Write response codes, burst length and the burst engine states.
 */

`default_nettype none

`include "dcache_cfg.svh"

package dcache_bus_pkg;

    // Every burst moves the whole line
    localparam int BURST_BEATS = `DC_LINE_WORDS;

    typedef logic [1:0] bus_resp_t;

    localparam bus_resp_t RESP_OKAY = 2'b00;

    // Write-back runs WB_*, refill runs FILL_*
    typedef enum logic [2:0] {
        IDLE,
        WB_ADDR,
        WB_DATA,
        WB_RESP,
        FILL_ADDR,
        FILL_DATA
    } burst_state_t;

endpackage

`default_nettype wire

/* verilog/dcache_addr_pkg.sv */
/*
 * Cache addressing types
 * Address, word, byte enable, tag and word index types, and the helpers
 * that slice a CPU address and build a line base address.
 */

`default_nettype none

`include "dcache_cfg.svh"

package dcache_addr_pkg;

    typedef logic [`DC_ADDR_W-1:0]                   addr_t;
    typedef logic [`DC_WORD_W-1:0]                   word_t;
    typedef logic [`DC_WORD_W/8-1:0]                 byte_en_t;
    // Address bits 31..9
    typedef logic [`DC_ADDR_W-`DC_TAG_LO-1:0]        line_tag_t;
    // Address bits 8..2
    typedef logic [`DC_TAG_LO-`DC_INDEX_LO-1:0]      word_index_t;

    function automatic line_tag_t addr_tag(addr_t a);
        return a[`DC_ADDR_W-1:`DC_TAG_LO];
    endfunction

    function automatic word_index_t addr_index(addr_t a);
        return a[`DC_TAG_LO-1:`DC_INDEX_LO];
    endfunction

    // Line base address, index and offset bits zero
    function automatic addr_t tag_base(line_tag_t t);
        return {t, {`DC_TAG_LO{1'b0}}};
    endfunction

    // Expand byte enables into a bit mask over the word
    function automatic word_t byte_mask(byte_en_t be);
        word_t mask;
        for (int b = 0; b < `DC_WORD_W/8; b++) begin
            mask[8*b +: 8] = {8{be[b]}};
        end
        return mask;
    endfunction

endpackage

`default_nettype wire

/* verilog/dcache_cfg.svh */
/*
 * Data cache configuration
 * Sizes and address bit positions shared by the packages and the RTL.
 * One direct-mapped line of 128 words, 32-bit words, 32-bit byte addresses.
 */

`ifndef DCACHE_CFG_SVH
`define DCACHE_CFG_SVH

// Byte address width
`define DC_ADDR_W 32

// Data word width, a whole number of bytes
`define DC_WORD_W 32

// Words held by the single cache line
`define DC_LINE_WORDS 128

// Lowest address bit of the word index inside the line
`define DC_INDEX_LO 2

// Lowest address bit of the line tag
`define DC_TAG_LO 9

`endif
